// File: hw/shift_pkg.sv
`default_nettype none

package shift_pkg;

   // ==========================================================================
   // widths
   // ==========================================================================
   localparam int unsigned data_width   = 32;
   localparam int unsigned amount_width = 6;   // two's complement shift amount.
   localparam int unsigned addr_width   = 4;

   // ==========================================================================
   // register map
   // ==========================================================================
   localparam logic [addr_width-1:0] addr_operand = 4'h0;
   localparam logic [addr_width-1:0] addr_amount  = 4'h4;   // write launches a shift.
   localparam logic [addr_width-1:0] addr_result  = 4'h8;
   localparam logic [addr_width-1:0] addr_status  = 4'hc;

   // status register bit positions.
   localparam int unsigned stat_busy     = 0;
   localparam int unsigned stat_carry    = 1;
   localparam int unsigned stat_ovf16    = 2;
   localparam int unsigned stat_ovf32    = 3;
   localparam int unsigned stat_zero     = 4;
   localparam int unsigned stat_negative = 5;

   // shift engine states.
   localparam logic [1:0] eng_idle    = 2'b00;
   localparam logic [1:0] eng_running = 2'b01;
   localparam logic [1:0] eng_last    = 2'b10;

   // ==========================================================================
   // records passed between pipeline stages
   // ==========================================================================
   typedef struct packed {
      logic [data_width-1:0]   operand;
      logic [amount_width-1:0] amount;
   } shift_cmd_t;

   typedef struct packed {
      logic [data_width-1:0] value;
      logic                  last_bit;
      logic                  sign_change16;
      logic                  sign_change32;
   } engine_out_t;

   typedef struct packed {
      logic [data_width-1:0] value;
      logic                  carry;
      logic                  ovf16;
      logic                  ovf32;
      logic                  zero;
      logic                  negative;
   } shift_result_t;

endpackage

`default_nettype wire

// File: hw/apb_shift_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_shift_regs
(
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   psel,
   input  logic                                   penable,
   input  logic                                   pwrite,
   input  logic [shift_pkg::addr_width-1:0]       paddr,
   input  logic [shift_pkg::data_width-1:0]       pwdata,
   output logic [shift_pkg::data_width-1:0]       prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   output shift_pkg::shift_cmd_t                  cmd,
   output logic                                   cmd_start,
   input  shift_pkg::shift_result_t               result,
   input  logic                                   result_valid
);

   logic                              access;       // apb access phase.
   logic                              sel_operand;
   logic                              sel_amount;
   logic                              sel_result;
   logic                              sel_status;
   logic                              addr_known;
   logic                              ro_write;
   logic                              busy_write;
   logic                              wr_ok;
   logic                              busy;
   shift_pkg::shift_result_t          result_q;
   logic [shift_pkg::data_width-1:0]  status_word;

   // ==========================================================================
   // address decode and error detection
   // ==========================================================================
   assign access      = psel & penable;
   assign sel_operand = (paddr == shift_pkg::addr_operand);
   assign sel_amount  = (paddr == shift_pkg::addr_amount);
   assign sel_result  = (paddr == shift_pkg::addr_result);
   assign sel_status  = (paddr == shift_pkg::addr_status);
   assign addr_known  = sel_operand | sel_amount | sel_result | sel_status;

   assign ro_write   = pwrite & (sel_result | sel_status);
   assign busy_write = pwrite & busy & (sel_operand | sel_amount);   // refused.

   assign pready  = 1'b1;   // no wait states.
   assign pslverr = access & (~addr_known | ro_write | busy_write);
   assign wr_ok   = access & pwrite & addr_known & ~ro_write & ~busy_write;

   // ==========================================================================
   // command registers, busy tracking and result capture
   // ==========================================================================
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cmd       <= '0;
         cmd_start <= 1'b0;
      end
      else
      begin
         cmd_start <= 1'b0;
         if (wr_ok && sel_operand)
            cmd.operand <= pwdata;
         if (wr_ok && sel_amount)
         begin
            cmd.amount <= pwdata[shift_pkg::amount_width-1:0];
            cmd_start  <= 1'b1;   // one cycle launch pulse.
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         busy <= 1'b0;
      else if (wr_ok && sel_amount)
         busy <= 1'b1;
      else if (result_valid)
         busy <= 1'b0;   // flag stage finished.
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         result_q <= '0;
      else if (result_valid)
         result_q <= result;
   end

   // ==========================================================================
   // read path
   // ==========================================================================
   always_comb
   begin
      status_word = '0;
      status_word[shift_pkg::stat_busy]     = busy;
      status_word[shift_pkg::stat_carry]    = result_q.carry;
      status_word[shift_pkg::stat_ovf16]    = result_q.ovf16;
      status_word[shift_pkg::stat_ovf32]    = result_q.ovf32;
      status_word[shift_pkg::stat_zero]     = result_q.zero;
      status_word[shift_pkg::stat_negative] = result_q.negative;
   end

   always_comb
   begin
      prdata = '0;
      if (psel && !pwrite)
      begin
         if (sel_operand)
            prdata = cmd.operand;
         else if (sel_amount)
            prdata = {{(shift_pkg::data_width-shift_pkg::amount_width){1'b0}}, cmd.amount};
         else if (sel_result)
            prdata = result_q.value;
         else if (sel_status)
            prdata = status_word;
      end
   end

endmodule

`default_nettype wire

// File: hw/shift_engine.sv
`timescale 1ns/10ps
`default_nettype none

module shift_engine
(
   input  logic                      clk,
   input  logic                      reset,
   input  shift_pkg::shift_cmd_t     cmd,
   input  logic                      start,
   output shift_pkg::engine_out_t    eng_out,
   output logic                      done
);

   localparam int unsigned msb = shift_pkg::data_width - 1;

   logic [1:0]                          state;
   logic [1:0]                          next_state;
   logic [shift_pkg::amount_width-1:0]  count;
   logic                                up;           // left shift.
   logic                                final_step;
   logic                                sign_diff16;
   logic                                sign_diff32;

   // amount sign picks the direction; cmd is held stable while busy.
   assign up = ~cmd.amount[shift_pkg::amount_width-1];

   // left counts down to 1, right counts up to -1.
   assign final_step = up ? (count == {{(shift_pkg::amount_width-1){1'b0}}, 1'b1})
                          : (count == '1);

   assign sign_diff16 = eng_out.value[15] ^ eng_out.value[14];
   assign sign_diff32 = eng_out.value[msb] ^ eng_out.value[msb-1];

   assign done = (state == shift_pkg::eng_last);

   // ==========================================================================
   // state machine
   // ==========================================================================
   always_comb
   begin
      next_state = state;
      case (state)
         shift_pkg::eng_idle:
            if (start)
               next_state = (cmd.amount == '0) ? shift_pkg::eng_last
                                               : shift_pkg::eng_running;
         shift_pkg::eng_running:
            if (final_step)
               next_state = shift_pkg::eng_last;
         default:
            next_state = shift_pkg::eng_idle;   // done lasts one cycle.
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= shift_pkg::eng_idle;
      else
         state <= next_state;
   end

   // ==========================================================================
   // shift datapath
   // ==========================================================================
   always_ff @(posedge clk)
   begin
      if (state == shift_pkg::eng_idle)
      begin
         count                 <= cmd.amount;
         eng_out.value         <= cmd.operand;
         eng_out.last_bit      <= 1'b0;
         eng_out.sign_change16 <= 1'b0;
         eng_out.sign_change32 <= 1'b0;
      end
      else if (state == shift_pkg::eng_running)
      begin
         if (up)
         begin
            eng_out.last_bit <= eng_out.value[msb];
            eng_out.value    <= {eng_out.value[msb-1:0], 1'b0};   // zero fill.
            count            <= count - 1'b1;
            if (sign_diff16)
               eng_out.sign_change16 <= 1'b1;   // sticky.
            if (sign_diff32)
               eng_out.sign_change32 <= 1'b1;
         end
         else
         begin
            eng_out.last_bit <= eng_out.value[0];
            eng_out.value    <= {cmd.operand[msb], eng_out.value[msb:1]};   // sign fill.
            count            <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/shift_flags.sv
`timescale 1ns/10ps
`default_nettype none

module shift_flags
(
   input  logic                        clk,
   input  logic                        reset,
   input  shift_pkg::engine_out_t      eng_out,
   input  logic                        eng_done,
   output shift_pkg::shift_result_t    result,
   output logic                        result_valid
);

   logic is_zero;
   logic is_negative;

   // result flags, from the engine value.
   assign is_zero     = (eng_out.value == '0);
   assign is_negative = eng_out.value[shift_pkg::data_width-1];

   // ==========================================================================
   // result record
   // ==========================================================================
   always_ff @(posedge clk)
   begin
      if (reset)
         result_valid <= 1'b0;
      else
         result_valid <= eng_done;   // one cycle behind done.
   end

   // holds until the next command completes.
   always_ff @(posedge clk)
   begin
      if (eng_done)
      begin
         result.value    <= eng_out.value;
         result.carry    <= eng_out.last_bit;
         result.ovf16    <= eng_out.sign_change16;
         result.ovf32    <= eng_out.sign_change32;
         result.zero     <= is_zero;
         result.negative <= is_negative;
      end
   end

endmodule

`default_nettype wire

// File: hw/shift_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module shift_unit_top
(
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [shift_pkg::addr_width-1:0]   paddr,
   input  logic [shift_pkg::data_width-1:0]   pwdata,
   output logic [shift_pkg::data_width-1:0]   prdata,
   output logic                               pready,
   output logic                               pslverr
);

   shift_pkg::shift_cmd_t      cmd;
   logic                       cmd_start;
   shift_pkg::engine_out_t     eng_out;
   logic                       eng_done;
   shift_pkg::shift_result_t   result;
   logic                       result_valid;

   // register front end.
   apb_shift_regs regs0
   (
      .clk          (clk),
      .reset        (reset),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .cmd          (cmd),
      .cmd_start    (cmd_start),
      .result       (result),
      .result_valid (result_valid)
   );

   // serial shifter, one bit per cycle.
   shift_engine engine0
   (
      .clk     (clk),
      .reset   (reset),
      .cmd     (cmd),
      .start   (cmd_start),
      .eng_out (eng_out),
      .done    (eng_done)
   );

   shift_flags flags0
   (
      .clk          (clk),
      .reset        (reset),
      .eng_out      (eng_out),
      .eng_done     (eng_done),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

`default_nettype wire

// File: dv/shift_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module shift_unit_tb;

   localparam int          half_period     = 10;
   localparam logic [31:0] lfsr_seed       = 32'd96940;
   localparam logic [31:0] lfsr_taps       = 32'h8020_0003;
   localparam int          random_ops      = 40;
   localparam int          num_ops         = random_ops + 15;   // 15 directed shifts.
   localparam int          watchdog_cycles = num_ops * 60 + 500;
   localparam int          max_polls       = 40;

   logic                                    clk;
   logic                                    reset;
   logic                                    psel;
   logic                                    penable;
   logic                                    pwrite;
   logic [shift_pkg::addr_width-1:0]        paddr;
   logic [shift_pkg::data_width-1:0]        pwdata;
   logic [shift_pkg::data_width-1:0]        prdata;
   logic                                    pready;
   logic                                    pslverr;

   int          error_count;
   int          check_count;
   logic [31:0] lfsr_state;

   shift_unit_top dut0
   (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #(half_period) clk = ~clk;

   // ========================================================================
   // checking helpers
   // ========================================================================
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
      end
   endtask

   // ========================================================================
   // reference model and random source
   // ========================================================================
   function automatic shift_pkg::shift_result_t model_shift(input logic [31:0] op,
                                                            input logic [5:0]  amt);
      shift_pkg::shift_result_t r;
      logic [31:0]              t;
      logic [31:0]              shifted_out;
      int                       n;
      int                       m;
      int                       k;
      r = '0;
      if (amt == 6'd0)
         r.value = op;                        // pass through.
      else if (!amt[5])
      begin
         n           = {27'd0, amt[4:0]};
         r.value     = op << n;
         shifted_out = op >> (32 - n);        // last bit to leave bit 31.
         r.carry     = shifted_out[0];
         for (k = 0; k < n; k++)
         begin
            t = op << k;                      // value before shift k+1.
            if (t[15] != t[14])
               r.ovf16 = 1'b1;
            if (t[31] != t[30])
               r.ovf32 = 1'b1;
         end
      end
      else
      begin
         m = 64 - {26'd0, amt};               // magnitude of the negative amount.
         if (m == 32)
            r.value = {32{op[31]}};
         else
            r.value = $unsigned($signed(op) >>> m);
         shifted_out = op >> (m - 1);
         r.carry     = shifted_out[0];
      end
      r.zero     = (r.value == 32'd0);
      r.negative = r.value[31];
      return r;
   endfunction

   function automatic logic [31:0] status_of(input shift_pkg::shift_result_t r);
      logic [31:0] s;
      s = '0;                                 // busy is low once done.
      s[shift_pkg::stat_carry]    = r.carry;
      s[shift_pkg::stat_ovf16]    = r.ovf16;
      s[shift_pkg::stat_ovf32]    = r.ovf32;
      s[shift_pkg::stat_zero]     = r.zero;
      s[shift_pkg::stat_negative] = r.negative;
      return s;
   endfunction

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ lfsr_taps;
      else
         return s >> 1;
   endfunction

   // one lfsr step per bit taken.
   task automatic random_word(input int nbits, output logic [31:0] w);
      int i;
      w = '0;
      for (i = 0; i < nbits; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         w          = {w[30:0], lfsr_state[0]};
      end
   endtask

   // ========================================================================
   // apb transfers
   // ========================================================================
   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;                        // setup phase.
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      err = pslverr;
      check_flag("pready", 1'b1, pready);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);                         // mid access phase.
      data = prdata;
      err  = pslverr;
      check_flag("pready", 1'b1, pready);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_and_check(input logic [3:0] addr, input string name,
                                 input logic [31:0] expected);
      logic [31:0] data;
      logic        err;
      apb_read(addr, data, err);
      check_value(name, expected, data);
      check_flag("pslverr", 1'b0, err);
   endtask

   task automatic wait_idle;
      logic [31:0] data;
      logic        err;
      int          polls;
      polls = 0;
      data  = 32'd1;
      while (data[shift_pkg::stat_busy] && polls < max_polls)
      begin
         apb_read(shift_pkg::addr_status, data, err);
         polls++;
      end
      check_count++;
      if (data[shift_pkg::stat_busy])
      begin
         error_count++;
         $display("busy bit still set after %0d status polls at %0t", polls, $time);
      end
   endtask

   task automatic start_shift(input logic [31:0] op, input logic [5:0] amt);
      logic err;
      apb_write(shift_pkg::addr_operand, op, err);
      check_flag("pslverr", 1'b0, err);
      apb_write(shift_pkg::addr_amount, {26'd0, amt}, err);   // launches the shift.
      check_flag("pslverr", 1'b0, err);
   endtask

   task automatic check_outcome(input logic [31:0] op, input logic [5:0] amt);
      shift_pkg::shift_result_t expected;
      expected = model_shift(op, amt);
      read_and_check(shift_pkg::addr_result, "result", expected.value);
      read_and_check(shift_pkg::addr_status, "status", status_of(expected));
   endtask

   task automatic run_shift(input logic [31:0] op, input logic [5:0] amt);
      start_shift(op, amt);
      wait_idle();
      check_outcome(op, amt);
   endtask

   // ========================================================================
   // directed tests
   // ========================================================================
   task automatic test_reset_values;
      read_and_check(shift_pkg::addr_operand, "operand", 32'd0);
      read_and_check(shift_pkg::addr_amount, "amount", 32'd0);
      read_and_check(shift_pkg::addr_result, "result", 32'd0);
      read_and_check(shift_pkg::addr_status, "status", 32'd0);
   endtask

   task automatic test_left_shifts;
      run_shift(32'h4000_0000, 6'd1);         // only ovf32.
      run_shift(32'hc000_0000, 6'd1);
      run_shift(32'h0000_4000, 6'd15);        // only ovf16.
      run_shift(32'h1234_5678, 6'd16);
      run_shift(32'h0000_0001, 6'd31);
   endtask

   task automatic test_right_shifts;
      run_shift(32'h7fff_0001, 6'h3f);        // -1
      run_shift(32'h8000_0001, 6'h3f);
      run_shift(32'h8000_0000, 6'h21);        // -31
      run_shift(32'h4000_0000, 6'h21);
      run_shift(32'hc000_0000, 6'h20);        // -32, all sign bits.
      run_shift(32'h7fff_ffff, 6'h20);
   endtask

   task automatic test_zero_amount;
      run_shift(32'hdead_beef, 6'd0);
      run_shift(32'h0000_0000, 6'd0);         // zero flag.
      run_shift(32'h8000_0000, 6'd0);         // negative flag.
   endtask

   task automatic test_error_responses;
      logic [31:0] data;
      logic        err;
      start_shift(32'h0000_0003, 6'd31);      // long shift keeps busy high.
      apb_write(shift_pkg::addr_operand, 32'hffff_ffff, err);
      check_flag("pslverr", 1'b1, err);
      apb_write(shift_pkg::addr_amount, 32'd1, err);
      check_flag("pslverr", 1'b1, err);
      apb_read(shift_pkg::addr_status, data, err);
      check_flag("status busy", 1'b1, data[shift_pkg::stat_busy]);
      check_flag("pslverr", 1'b0, err);
      wait_idle();
      // read-only and unmapped accesses, with the unit idle.
      apb_write(shift_pkg::addr_result, 32'h1111_1111, err);
      check_flag("pslverr", 1'b1, err);
      apb_write(shift_pkg::addr_status, 32'h2222_2222, err);
      check_flag("pslverr", 1'b1, err);
      apb_read(4'h2, data, err);              // unmapped.
      check_flag("pslverr", 1'b1, err);
      apb_write(4'h1, 32'h3333_3333, err);
      check_flag("pslverr", 1'b1, err);
      check_outcome(32'h0000_0003, 6'd31);
      read_and_check(shift_pkg::addr_operand, "operand", 32'h0000_0003);
      read_and_check(shift_pkg::addr_amount, "amount", 32'd31);
   endtask

   task automatic test_random_shifts;
      logic [31:0] op;
      logic [31:0] w;
      int          i;
      for (i = 0; i < random_ops; i++)
      begin
         random_word(32, op);
         random_word(6, w);                   // every 6-bit code is a legal amount.
         run_shift(op, w[5:0]);
      end
   endtask

   // ========================================================================
   // main sequence and watchdog
   // ========================================================================
   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      error_count = 0;
      check_count = 0;
      lfsr_state  = lfsr_seed;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      test_reset_values();
      test_left_shifts();
      test_right_shifts();
      test_zero_amount();
      test_error_responses();
      test_random_shifts();

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
hw/shift_pkg.sv
hw/apb_shift_regs.sv
hw/shift_engine.sv
hw/shift_flags.sv
hw/shift_unit_top.sv
dv/shift_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the shift unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
sim_name=shift_unit_sim
log_file=sim.log

verilator --binary --timing \
   --timescale 1ns/10ps \
   --top-module shift_unit_tb \
   -Mdir "$build_dir" \
   -o "$sim_name" \
   -f build.f

sim_status=0
"./$build_dir/$sim_name" > "$log_file" 2>&1 || sim_status=$?
cat "$log_file"

if grep -q "all tests passed" "$log_file"; then
   echo "simulation PASSED"
else
   echo "simulation FAILED (exit status $sim_status)"
   exit 1
fi
